// File: source/io_system_pkg.sv
package io_system_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bus sizes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int port_width  = 16;
	localparam int data_width  = 32;
	localparam int byte_width  = 8;
	localparam int len_width   = 3;
	localparam int idx_width   = 2;
	localparam int fifo_depth  = 2;
	localparam int ptr_width   = $clog2(fifo_depth);
	localparam int count_width = $clog2(fifo_depth + 1);
	localparam int dev_count   = 13;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// port map
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// disk data blocks are 8 ports wide, the control port sits apart
	localparam logic [port_width-1:0] hdd0_data_base = 16'h01F0;
	localparam logic [port_width-1:0] hdd0_ctl_port  = 16'h03F6;
	localparam logic [port_width-1:0] hdd1_data_base = 16'h0170;
	localparam logic [port_width-1:0] hdd1_ctl_port  = 16'h0376;
	localparam logic [port_width-1:0] joystick_port  = 16'h0201;
	localparam logic [port_width-1:0] floppy_base    = 16'h03F0;
	localparam logic [port_width-1:0] dma_master_base = 16'h00C0;
	localparam logic [port_width-1:0] dma_page_base  = 16'h0080;
	localparam logic [port_width-1:0] dma_slave_base = 16'h0000;
	localparam logic [port_width-1:0] pic_master_base = 16'h0020;
	localparam logic [port_width-1:0] pic_slave_base = 16'h00A0;
	localparam logic [port_width-1:0] pit_base       = 16'h0040;
	localparam logic [port_width-1:0] pit_ctl_port   = 16'h0061;
	localparam logic [port_width-1:0] ps2_io_base    = 16'h0060;
	localparam logic [port_width-1:0] ps2_ctl_base   = 16'h0090;
	localparam logic [port_width-1:0] rtc_base       = 16'h0070;
	localparam logic [port_width-1:0] fm_base        = 16'h0388;
	localparam logic [port_width-1:0] sb_base        = 16'h0220;
	localparam logic [port_width-1:0] uart_base      = 16'h03F8;
	localparam logic [port_width-1:0] mpu_base       = 16'h0330;
	localparam logic [port_width-1:0] vga_first      = 16'h03B0;
	localparam logic [port_width-1:0] vga_last       = 16'h03DF;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// enums
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic {
		op_read,
		op_write
	} io_op_e;

	// the value doubles as the index into the read word array
	typedef enum logic [3:0] {
		dev_none,
		dev_hdd0,
		dev_hdd1,
		dev_floppy,
		dev_dma,
		dev_pic,
		dev_pit,
		dev_ps2,
		dev_rtc,
		dev_sound,
		dev_uart,
		dev_vga,
		dev_joystick
	} device_e;

	typedef enum logic [1:0] {
		st_idle,
		st_decode,
		st_access,
		st_finish
	} seq_state_e;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// structs
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		io_op_e                op;
		logic [port_width-1:0] address;
		logic [len_width-1:0]  length;
		logic [data_width-1:0] wdata;
	} io_req_t;

	typedef struct packed {
		logic [port_width-1:0] address;
		logic [data_width-1:0] wdata;
		logic [len_width-1:0]  size;
	} dev_cycle_t;

	typedef logic [dev_count-1:0][data_width-1:0] dev_rdata_t;

endpackage

// File: source/io_request_capture.sv
`timescale 1ns/1ps

module io_request_capture (
	input  logic                                  clk_sys,
	input  logic                                  rst_n,
	input  logic                                  read_do,
	input  logic [io_system_pkg::port_width-1:0]  read_address,
	input  logic [io_system_pkg::len_width-1:0]   read_length,
	input  logic                                  write_do,
	input  logic [io_system_pkg::port_width-1:0]  write_address,
	input  logic [io_system_pkg::len_width-1:0]   write_length,
	input  logic [io_system_pkg::data_width-1:0]  write_data,
	input  logic                                  read_done,
	input  logic                                  write_done,
	output logic                                  push,
	output io_system_pkg::io_req_t                push_req
);

	logic read_pend;
	logic write_pend;
	logic read_start;
	logic write_start;

	assign write_start = write_do && !write_pend;
	assign read_start  = read_do && !read_pend;

	// a write that starts with a read goes first, the read follows next cycle
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			push       <= 1'b0;
			read_pend  <= 1'b0;
			write_pend <= 1'b0;
		end else begin
			push <= write_start || read_start;
			if (write_start)
				write_pend <= 1'b1;
			else if (write_done)
				write_pend <= 1'b0;
			if (read_start && !write_start)
				read_pend <= 1'b1;
			else if (read_done)
				read_pend <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (write_start)
			push_req <= '{op: io_system_pkg::op_write, address: write_address,
				length: write_length, wdata: write_data};
		else if (read_start)
			push_req <= '{op: io_system_pkg::op_read, address: read_address,
				length: read_length, wdata: '0};
	end

	// the sequencer only finishes requests that were pushed from here
	read_done_pending: assert property (@(posedge clk_sys) disable iff (!rst_n)
		read_done |-> read_pend);
	write_done_pending: assert property (@(posedge clk_sys) disable iff (!rst_n)
		write_done |-> write_pend);

endmodule

// File: source/io_request_fifo.sv
`timescale 1ns/1ps

module io_request_fifo (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   push,
	input  io_system_pkg::io_req_t push_req,
	input  logic                   pop,
	output io_system_pkg::io_req_t head,
	output logic                   empty,
	output logic                   full
);

	io_system_pkg::io_req_t mem [io_system_pkg::fifo_depth];

	logic [io_system_pkg::ptr_width-1:0]   wr_ptr;
	logic [io_system_pkg::ptr_width-1:0]   rd_ptr;
	logic [io_system_pkg::count_width-1:0] count;

	function automatic logic [io_system_pkg::ptr_width-1:0] next_ptr(
		input logic [io_system_pkg::ptr_width-1:0] ptr
	);
		if (ptr == io_system_pkg::ptr_width'(io_system_pkg::fifo_depth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign head  = mem[rd_ptr];
	assign empty = (count == '0);
	assign full  = (count == io_system_pkg::count_width'(io_system_pkg::fifo_depth));

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (push)
			mem[wr_ptr] <= push_req;
	end

	// two channels with one request each can never exceed the depth
	no_overflow: assert property (@(posedge clk_sys) disable iff (!rst_n)
		push |-> !full);
	no_underflow: assert property (@(posedge clk_sys) disable iff (!rst_n)
		pop |-> !empty);

endmodule

// File: source/io_port_decoder.sv
`timescale 1ns/1ps

module io_port_decoder (
	input  logic                                 clk_sys,
	input  logic                                 rst_n,
	input  logic [io_system_pkg::port_width-1:0] address,
	output io_system_pkg::device_e               device_sel,
	output logic                                 is_wide
);

	logic hit_hdd0;
	logic hit_hdd1;
	io_system_pkg::device_e next_sel;

	// true when addr falls in the aligned block of 2**span_log2 ports at base
	function automatic logic in_block(
		input logic [io_system_pkg::port_width-1:0] addr,
		input logic [io_system_pkg::port_width-1:0] base,
		input int                                   span_log2
	);
		return (addr >> span_log2) == (base >> span_log2);
	endfunction

	assign hit_hdd0 = in_block(address, io_system_pkg::hdd0_data_base, 3)
		|| (address == io_system_pkg::hdd0_ctl_port);
	assign hit_hdd1 = in_block(address, io_system_pkg::hdd1_data_base, 3)
		|| (address == io_system_pkg::hdd1_ctl_port);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// priority decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// hdd0 is checked before the floppy so 3F6 lands on the disk
	always_comb begin
		if (hit_hdd0)
			next_sel = io_system_pkg::dev_hdd0;
		else if (hit_hdd1)
			next_sel = io_system_pkg::dev_hdd1;
		else if (address == io_system_pkg::joystick_port)
			next_sel = io_system_pkg::dev_joystick;
		else if (in_block(address, io_system_pkg::floppy_base, 3))
			next_sel = io_system_pkg::dev_floppy;
		else if (in_block(address, io_system_pkg::dma_master_base, 5)
			|| in_block(address, io_system_pkg::dma_page_base, 4)
			|| in_block(address, io_system_pkg::dma_slave_base, 4))
			next_sel = io_system_pkg::dev_dma;
		else if (in_block(address, io_system_pkg::pic_master_base, 1)
			|| in_block(address, io_system_pkg::pic_slave_base, 1))
			next_sel = io_system_pkg::dev_pic;
		else if (in_block(address, io_system_pkg::pit_base, 2)
			|| (address == io_system_pkg::pit_ctl_port))
			next_sel = io_system_pkg::dev_pit;
		else if (in_block(address, io_system_pkg::ps2_io_base, 3)
			|| in_block(address, io_system_pkg::ps2_ctl_base, 4))
			next_sel = io_system_pkg::dev_ps2;
		else if (in_block(address, io_system_pkg::rtc_base, 1))
			next_sel = io_system_pkg::dev_rtc;
		else if (in_block(address, io_system_pkg::fm_base, 2)
			|| in_block(address, io_system_pkg::sb_base, 4))
			next_sel = io_system_pkg::dev_sound;
		else if (in_block(address, io_system_pkg::uart_base, 3)
			|| in_block(address, io_system_pkg::mpu_base, 1))
			next_sel = io_system_pkg::dev_uart;
		else if (address >= io_system_pkg::vga_first && address <= io_system_pkg::vga_last)
			next_sel = io_system_pkg::dev_vga;
		else
			next_sel = io_system_pkg::dev_none;
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			device_sel <= io_system_pkg::dev_none;
			is_wide    <= 1'b0;
		end else begin
			device_sel <= next_sel;
			// disk data registers sit below bit 9, control ports above
			is_wide    <= (hit_hdd0 || hit_hdd1) && !address[9];
		end
	end

endmodule

// File: source/io_port_sequencer.sv
`timescale 1ns/1ps

module io_port_sequencer (
	input  logic                                 clk_sys,
	input  logic                                 rst_n,
	input  logic                                 empty,
	input  io_system_pkg::io_req_t               head,
	output logic                                 pop,
	output io_system_pkg::dev_cycle_t            dev_cycle,
	output io_system_pkg::device_e               dev_sel,
	output logic                                 dev_read,
	output logic                                 dev_write,
	input  io_system_pkg::dev_rdata_t            dev_rdata,
	output logic                                 read_done,
	output logic                                 write_done,
	output logic [io_system_pkg::data_width-1:0] read_data
);

	io_system_pkg::seq_state_e state;
	io_system_pkg::io_req_t    req;
	io_system_pkg::device_e    device_sel;

	logic                                 is_wide;
	logic [io_system_pkg::port_width-1:0] cur_addr;
	logic [io_system_pkg::idx_width-1:0]  byte_idx;
	logic [io_system_pkg::data_width-1:0] rdata_acc;
	logic [io_system_pkg::data_width-1:0] sampled_word;
	logic [io_system_pkg::byte_width-1:0] sampled_byte;
	logic [io_system_pkg::byte_width-1:0] write_byte;
	logic                                 last_byte;

	io_port_decoder decoder_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.address    (cur_addr),
		.device_sel (device_sel),
		.is_wide    (is_wide)
	);

	assign sampled_word = dev_rdata[device_sel];
	// unmapped ports float high on a real bus
	assign sampled_byte = (device_sel == io_system_pkg::dev_none)
		? '1 : sampled_word[io_system_pkg::byte_width-1:0];
	assign write_byte   = req.wdata[{byte_idx, 3'b000} +: io_system_pkg::byte_width];
	assign last_byte    = ({1'b0, byte_idx} + 3'd1) == req.length;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// processor and device outputs
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign pop        = (state == io_system_pkg::st_idle) && !empty;
	assign dev_read   = (state == io_system_pkg::st_access) && (req.op == io_system_pkg::op_read);
	assign dev_write  = (state == io_system_pkg::st_access) && (req.op == io_system_pkg::op_write);
	assign read_done  = (state == io_system_pkg::st_finish) && (req.op == io_system_pkg::op_read);
	assign write_done = (state == io_system_pkg::st_finish) && (req.op == io_system_pkg::op_write);
	assign read_data  = rdata_acc;

	// the select is only shown while a strobe is out
	assign dev_sel = (state == io_system_pkg::st_access) ? device_sel : io_system_pkg::dev_none;

	assign dev_cycle.address = cur_addr;
	assign dev_cycle.wdata   = is_wide ? req.wdata
		: {{(io_system_pkg::data_width - io_system_pkg::byte_width){1'b0}}, write_byte};
	assign dev_cycle.size    = is_wide ? req.length : io_system_pkg::len_width'(1);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state <= io_system_pkg::st_idle;
		end else begin
			case (state)
				io_system_pkg::st_idle: begin
					if (!empty)
						state <= io_system_pkg::st_decode;
				end
				io_system_pkg::st_decode: begin
					state <= io_system_pkg::st_access;
				end
				io_system_pkg::st_access: begin
					// a wide port takes the whole request in one cycle
					if (is_wide || last_byte)
						state <= io_system_pkg::st_finish;
					else
						state <= io_system_pkg::st_decode;
				end
				default: begin
					state <= io_system_pkg::st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (pop) begin
			req       <= head;
			cur_addr  <= head.address;
			byte_idx  <= '0;
			rdata_acc <= '0;
		end
		if (state == io_system_pkg::st_access) begin
			if (req.op == io_system_pkg::op_read) begin
				if (is_wide)
					rdata_acc <= sampled_word;
				else
					rdata_acc[{byte_idx, 3'b000} +: io_system_pkg::byte_width] <= sampled_byte;
			end
			cur_addr <= cur_addr + 1'b1;
			byte_idx <= byte_idx + 1'b1;
		end
	end

	no_read_write_overlap: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(dev_read && dev_write));

endmodule

// File: source/io_system.sv
`timescale 1ns/1ps

module io_system (
	input  logic                                 clk_sys,
	input  logic                                 rst_n,

	input  logic                                 read_do,
	input  logic [io_system_pkg::port_width-1:0] read_address,
	input  logic [io_system_pkg::len_width-1:0]  read_length,
	output logic [io_system_pkg::data_width-1:0] read_data,
	output logic                                 read_done,
	input  logic                                 write_do,
	input  logic [io_system_pkg::port_width-1:0] write_address,
	input  logic [io_system_pkg::len_width-1:0]  write_length,
	input  logic [io_system_pkg::data_width-1:0] write_data,
	output logic                                 write_done,

	output io_system_pkg::dev_cycle_t            dev_cycle,
	output io_system_pkg::device_e               dev_sel,
	output logic                                 dev_read,
	output logic                                 dev_write,
	input  io_system_pkg::dev_rdata_t            dev_rdata
);

	io_system_pkg::io_req_t push_req;
	io_system_pkg::io_req_t head;

	logic push;
	logic pop;
	logic empty;

	io_request_capture capture_i (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.read_do       (read_do),
		.read_address  (read_address),
		.read_length   (read_length),
		.write_do      (write_do),
		.write_address (write_address),
		.write_length  (write_length),
		.write_data    (write_data),
		.read_done     (read_done),
		.write_done    (write_done),
		.push          (push),
		.push_req      (push_req)
	);

	io_request_fifo fifo_i (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.push     (push),
		.push_req (push_req),
		.pop      (pop),
		.head     (head),
		.empty    (empty),
		.full     ()
	);

	io_port_sequencer sequencer_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.empty      (empty),
		.head       (head),
		.pop        (pop),
		.dev_cycle  (dev_cycle),
		.dev_sel    (dev_sel),
		.dev_read   (dev_read),
		.dev_write  (dev_write),
		.dev_rdata  (dev_rdata),
		.read_done  (read_done),
		.write_done (write_done),
		.read_data  (read_data)
	);

endmodule

// File: verification/io_system_tb_clock.sv
`timescale 1ns/1ps

module io_system_tb_clock (
	output logic clk_sys,
	output logic rst_n
);

	// 40 ns period
	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// reset lets go in the drive slot after the third rising edge
	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk_sys);
		#2;
		rst_n = 1'b1;
	end

endmodule

// File: verification/io_system_tb.sv
`timescale 1ns/1ps

module io_system_tb;

	// 40 cycles for every byte moved by the tests, plus reset and idle time
	localparam int test_bytes    = 16;
	localparam int timeout_limit = 40 * test_bytes + 200;

	logic                                 clk_sys;
	logic                                 rst_n;
	logic                                 read_do;
	logic [io_system_pkg::port_width-1:0] read_address;
	logic [io_system_pkg::len_width-1:0]  read_length;
	logic [io_system_pkg::data_width-1:0] read_data;
	logic                                 read_done;
	logic                                 write_do;
	logic [io_system_pkg::port_width-1:0] write_address;
	logic [io_system_pkg::len_width-1:0]  write_length;
	logic [io_system_pkg::data_width-1:0] write_data;
	logic                                 write_done;
	io_system_pkg::dev_cycle_t            dev_cycle;
	io_system_pkg::device_e               dev_sel;
	logic                                 dev_read;
	logic                                 dev_write;
	io_system_pkg::dev_rdata_t            dev_rdata;

	io_system_pkg::dev_cycle_t cyc_q[$];
	io_system_pkg::device_e    dev_q[$];
	io_system_pkg::io_op_e     op_q[$];
	int                        read_done_count = 0;
	int                        write_done_count = 0;
	int                        cycle_count = 0;
	integer                    seed = 32'h929c;

	io_system_tb_clock clock_gen_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n)
	);

	io_system dut_i (.*);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// device model and monitor
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// the low byte carries the device number so byte reads show who answered
	task automatic build_device_words();
		logic [31:0] r;
		for (int i = 0; i < io_system_pkg::dev_count; i++) begin
			r = $random(seed);
			dev_rdata[4'(i)] = {r[31:8], 4'(i), r[3:0]};
		end
	endtask

	always @(negedge clk_sys) begin
		if (rst_n) begin
			if (dev_read || dev_write) begin
				cyc_q.push_back(dev_cycle);
				dev_q.push_back(dev_sel);
				op_q.push_back(dev_write ? io_system_pkg::op_write : io_system_pkg::op_read);
			end
			if (read_done)
				read_done_count++;
			if (write_done)
				write_done_count++;
		end
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			$display("timeout: the tests did not finish within %0d cycles", timeout_limit);
			$display("RESULT: FAIL");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// compare tasks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic fail_run(input string msg);
		$display("[ERROR] %0t ns: %s", $time, msg);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
			fail_run($sformatf("%s: got %0d, expected %0d", what, got, exp));
	endtask

	task automatic check_data(
		input logic [io_system_pkg::data_width-1:0] got,
		input logic [io_system_pkg::data_width-1:0] exp,
		input string                                what
	);
		if (got !== exp)
			fail_run($sformatf("%s: got %h, expected %h", what, got, exp));
	endtask

	task automatic check_device(
		input io_system_pkg::device_e got,
		input io_system_pkg::device_e exp,
		input string                  what
	);
		if (got !== exp)
			fail_run($sformatf("%s: got %s, expected %s", what, got.name(), exp.name()));
	endtask

	// write data only means something on write cycles
	task automatic check_cycle(
		input io_system_pkg::dev_cycle_t got_cycle,
		input io_system_pkg::device_e    got_dev,
		input io_system_pkg::io_op_e     got_op,
		input io_system_pkg::dev_cycle_t exp_cycle,
		input io_system_pkg::device_e    exp_dev,
		input io_system_pkg::io_op_e     exp_op,
		input string                     what
	);
		logic  bad;
		string got_text;
		string exp_text;
		bad = (got_dev !== exp_dev) || (got_op !== exp_op)
			|| (got_cycle.address !== exp_cycle.address) || (got_cycle.size !== exp_cycle.size);
		if (exp_op == io_system_pkg::op_write && got_cycle.wdata !== exp_cycle.wdata)
			bad = 1'b1;
		if (bad) begin
			got_text = $sformatf("%s %s at %h size %0d data %h", got_op.name(), got_dev.name(),
				got_cycle.address, got_cycle.size, got_cycle.wdata);
			exp_text = $sformatf("%s %s at %h size %0d data %h", exp_op.name(), exp_dev.name(),
				exp_cycle.address, exp_cycle.size, exp_cycle.wdata);
			fail_run($sformatf("%s: got %s, expected %s", what, got_text, exp_text));
		end
	endtask

	task automatic expect_cycle(
		input int                                   idx,
		input logic [io_system_pkg::port_width-1:0] address,
		input logic [io_system_pkg::data_width-1:0] wdata,
		input logic [io_system_pkg::len_width-1:0]  size,
		input io_system_pkg::device_e               exp_dev,
		input io_system_pkg::io_op_e                exp_op,
		input string                                what
	);
		io_system_pkg::dev_cycle_t exp_cycle;
		exp_cycle = '{address: address, wdata: wdata, size: size};
		check_cycle(cyc_q[idx], dev_q[idx], op_q[idx], exp_cycle, exp_dev, exp_op, what);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// drivers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic drive_slot();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic clear_record();
		cyc_q.delete();
		dev_q.delete();
		op_q.delete();
		read_done_count = 0;
		write_done_count = 0;
	endtask

	function automatic io_system_pkg::io_req_t make_req(
		input io_system_pkg::io_op_e                req_op,
		input logic [io_system_pkg::port_width-1:0] req_address,
		input logic [io_system_pkg::len_width-1:0]  req_length,
		input logic [io_system_pkg::data_width-1:0] req_wdata
	);
		return '{op: req_op, address: req_address, length: req_length, wdata: req_wdata};
	endfunction

	// a length of zero leaves that channel unused
	task automatic run_requests(
		input  io_system_pkg::io_req_t              wr,
		input  io_system_pkg::io_req_t              rd,
		output logic [io_system_pkg::data_width-1:0] data
	);
		logic wr_wait;
		logic rd_wait;
		logic wr_fin;
		logic rd_fin;
		data = '0;
		drive_slot();
		write_address = wr.address;
		write_length  = wr.length;
		write_data    = wr.wdata;
		write_do      = (wr.length != '0);
		read_address  = rd.address;
		read_length   = rd.length;
		read_do       = (rd.length != '0);
		wr_wait = write_do;
		rd_wait = read_do;
		while (wr_wait || rd_wait) begin
			@(negedge clk_sys);
			wr_fin = write_done;
			rd_fin = read_done;
			if (rd_fin)
				data = read_data;
			// the level drops in the slot after its done pulse
			if (wr_fin || rd_fin) begin
				drive_slot();
				if (wr_fin) begin
					write_do = 1'b0;
					wr_wait = 1'b0;
				end
				if (rd_fin) begin
					read_do = 1'b0;
					rd_wait = 1'b0;
				end
			end
		end
		repeat (4) @(negedge clk_sys);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic idle_stays_quiet();
		repeat (10) begin
			@(negedge clk_sys);
			check_device(dev_sel, io_system_pkg::dev_none, "dev_sel while idle");
			check_count(int'(dev_read) + int'(dev_write) + int'(read_done) + int'(write_done),
				0, "strobes and done pulses while idle");
		end
	endtask

	task automatic write_one_byte(
		input logic [io_system_pkg::port_width-1:0] address,
		input io_system_pkg::device_e               exp_dev
	);
		logic [io_system_pkg::data_width-1:0] wd;
		logic [io_system_pkg::data_width-1:0] unused;
		wd = $random(seed);
		clear_record();
		run_requests(make_req(io_system_pkg::op_write, address, 3'd1, wd),
			make_req(io_system_pkg::op_read, '0, 3'd0, '0), unused);
		check_count(cyc_q.size(), 1, $sformatf("cycles for a byte write at %h", address));
		expect_cycle(0, address, {24'h0, wd[7:0]}, 3'd1, exp_dev, io_system_pkg::op_write,
			$sformatf("byte write at %h", address));
		check_count(write_done_count, 1, "write_done pulses");
	endtask

	task automatic byte_writes();
		write_one_byte(16'h0021, io_system_pkg::dev_pic);
		write_one_byte(16'h0061, io_system_pkg::dev_pit);
		write_one_byte(16'h03F9, io_system_pkg::dev_uart);
	endtask

	task automatic byte_reads();
		logic [io_system_pkg::data_width-1:0] word;
		io_system_pkg::io_req_t               no_req;
		no_req = make_req(io_system_pkg::op_write, '0, 3'd0, '0);
		clear_record();
		run_requests(no_req, make_req(io_system_pkg::op_read, 16'h03F7, 3'd2, '0), word);
		check_count(cyc_q.size(), 2, "cycles for a 2-byte read at 3F7");
		expect_cycle(0, 16'h03F7, '0, 3'd1, io_system_pkg::dev_floppy, io_system_pkg::op_read,
			"byte 0 at 3F7");
		expect_cycle(1, 16'h03F8, '0, 3'd1, io_system_pkg::dev_uart, io_system_pkg::op_read,
			"byte 1 at 3F8");
		check_data(word, {16'h0, dev_rdata[io_system_pkg::dev_uart][7:0],
			dev_rdata[io_system_pkg::dev_floppy][7:0]}, "read word at 3F7");
		clear_record();
		run_requests(no_req, make_req(io_system_pkg::op_read, 16'h03F6, 3'd1, '0), word);
		check_count(cyc_q.size(), 1, "cycles for a byte read at 3F6");
		expect_cycle(0, 16'h03F6, '0, 3'd1, io_system_pkg::dev_hdd0, io_system_pkg::op_read,
			"byte read at 3F6");
		check_data(word, {24'h0, dev_rdata[io_system_pkg::dev_hdd0][7:0]}, "read word at 3F6");
	endtask

	task automatic wide_disk_read();
		logic [io_system_pkg::data_width-1:0] word;
		clear_record();
		run_requests(make_req(io_system_pkg::op_write, '0, 3'd0, '0),
			make_req(io_system_pkg::op_read, 16'h01F0, 3'd4, '0), word);
		check_count(cyc_q.size(), 1, "cycles for a 4-byte read at 1F0");
		expect_cycle(0, 16'h01F0, '0, 3'd4, io_system_pkg::dev_hdd0, io_system_pkg::op_read,
			"wide read at 1F0");
		check_data(word, dev_rdata[io_system_pkg::dev_hdd0], "read word at 1F0");
	endtask

	task automatic unmapped_read();
		logic [io_system_pkg::data_width-1:0] word;
		clear_record();
		run_requests(make_req(io_system_pkg::op_write, '0, 3'd0, '0),
			make_req(io_system_pkg::op_read, 16'h0300, 3'd2, '0), word);
		check_count(cyc_q.size(), 2, "cycles for a 2-byte read at 300");
		expect_cycle(0, 16'h0300, '0, 3'd1, io_system_pkg::dev_none, io_system_pkg::op_read,
			"byte 0 at 300");
		expect_cycle(1, 16'h0301, '0, 3'd1, io_system_pkg::dev_none, io_system_pkg::op_read,
			"byte 1 at 301");
		check_data(word, 32'h0000FFFF, "read word at 300");
	endtask

	// the write is queued first when both channels start together
	task automatic read_and_write_together();
		logic [io_system_pkg::data_width-1:0] wd;
		logic [io_system_pkg::data_width-1:0] word;
		wd = $random(seed);
		clear_record();
		run_requests(make_req(io_system_pkg::op_write, 16'h0070, 3'd2, wd),
			make_req(io_system_pkg::op_read, 16'h0060, 3'd2, '0), word);
		check_count(cyc_q.size(), 4, "cycles for a write and a read together");
		expect_cycle(0, 16'h0070, {24'h0, wd[7:0]}, 3'd1, io_system_pkg::dev_rtc,
			io_system_pkg::op_write, "write byte 0 at 70");
		expect_cycle(1, 16'h0071, {24'h0, wd[15:8]}, 3'd1, io_system_pkg::dev_rtc,
			io_system_pkg::op_write, "write byte 1 at 71");
		expect_cycle(2, 16'h0060, '0, 3'd1, io_system_pkg::dev_ps2, io_system_pkg::op_read,
			"read byte 0 at 60");
		expect_cycle(3, 16'h0061, '0, 3'd1, io_system_pkg::dev_pit, io_system_pkg::op_read,
			"read byte 1 at 61");
		check_data(word, {16'h0, dev_rdata[io_system_pkg::dev_pit][7:0],
			dev_rdata[io_system_pkg::dev_ps2][7:0]}, "read word at 60");
		check_count(write_done_count, 1, "write_done pulses");
		check_count(read_done_count, 1, "read_done pulses");
	endtask

	initial begin
		read_do       = 1'b0;
		read_address  = '0;
		read_length   = '0;
		write_do      = 1'b0;
		write_address = '0;
		write_length  = '0;
		write_data    = '0;
		dev_rdata     = '0;
		build_device_words();
		wait (rst_n === 1'b1);
		idle_stays_quiet();
		byte_writes();
		byte_reads();
		wide_disk_read();
		unmapped_read();
		read_and_write_together();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: io_system.f
source/io_system_pkg.sv
source/io_request_capture.sv
source/io_request_fifo.sv
source/io_port_decoder.sv
source/io_port_sequencer.sv
source/io_system.sv
verification/io_system_tb_clock.sv
verification/io_system_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f io_system.f --top-module io_system_tb -Mdir obj_dir -o io_system_sim \
	|| { echo "build failed"; exit 1; }

sim_output="$(./obj_dir/io_system_sim)"
echo "$sim_output"
echo "$sim_output" | grep -qx "RESULT: PASS" && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
